//--- regfile_pkg.sv
package regfile_pkg;

  // ========================================
  // Register file geometry
  // ========================================

  // Number of architectural integer registers
  localparam int reg_count = 64;

  // Width of one register and its split into byte lanes
  localparam int data_wid   = 64;
  localparam int byte_lanes = data_wid / 8;

  // Register number wide enough for every register
  typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

  // ========================================
  // Special registers
  // ========================================

  // Hard-wired zero whose writes are dropped on the read side
  localparam reg_addr_t zero_reg = 6'd0;

  // Reads return the program counter of the issuing group
  localparam reg_addr_t pc_reg = 6'd53;

  // ========================================
  // Shared types
  // ========================================

  // One register value taken either as a whole word or lane by lane
  typedef union packed {
    logic [data_wid-1:0]        word;
    logic [byte_lanes-1:0][7:0] lanes;
  } reg_word_u;

  // One write port of 79 bits
  // There is no handshake so a write with en set always lands
  typedef struct packed {
    logic                  en;
    logic [byte_lanes-1:0] be;
    reg_addr_t             addr;
    logic [data_wid-1:0]   data;
  } wr_port_t;

endpackage

//--- regfile_bank_ram.sv
`timescale 1ns/1ns

module regfile_bank_ram #(
  parameter int DEPTH = 64
) (
  input  logic                            clka,
  input  regfile_pkg::wr_port_t           wr,
  input  regfile_pkg::reg_addr_t          raddr,
  output logic [regfile_pkg::data_wid-1:0] rdata
);

  import regfile_pkg::*;

  // One copy of a bank dedicated to a single read port
  // Small enough to map onto LUT RAM with an asynchronous read
  (* ram_style = "distributed" *)
  logic [byte_lanes-1:0][7:0] mem [DEPTH];

  // Each lane of a write lands only when its byte enable is set
  always_ff @(posedge clka) begin
    if (wr.en) begin
      for (int i = 0; i < byte_lanes; i++) begin
        if (wr.be[i]) begin
          mem[wr.addr][i] <= wr.data[8*i +: 8];
        end
      end
    end
  end

  // Zero-latency read of the addressed word
  assign rdata = mem[raddr];

endmodule

//--- regfile_lvt.sv
`timescale 1ns/1ns

module regfile_lvt #(
  parameter int NUM_READ = 4
) (
  input  logic                              clka,
  input  logic                              reset,
  input  regfile_pkg::wr_port_t             wr0,
  input  regfile_pkg::wr_port_t             wr1,
  input  regfile_pkg::reg_addr_t            ra    [NUM_READ],
  output logic [regfile_pkg::byte_lanes-1:0] owner [NUM_READ]
);

  import regfile_pkg::*;

  // ========================================
  // Live-value table
  // ========================================

  // One bit per byte of every register
  // A set bit means the latest value of that byte sits in bank 1
  logic [byte_lanes-1:0] own_q [reg_count];

  // Each written lane moves to the port that wrote it
  // The wr1 update is issued after the wr0 update, so on a collision in
  // the same register and lane the later assignment leaves bank 1 as owner
  always_ff @(posedge clka) begin
    if (reset) begin
      for (int r = 0; r < reg_count; r++) begin
        own_q[r] <= '0;
      end
    end else begin
      if (wr0.en) begin
        for (int i = 0; i < byte_lanes; i++) begin
          if (wr0.be[i]) begin
            own_q[wr0.addr][i] <= 1'b0;
          end
        end
      end
      if (wr1.en) begin
        for (int i = 0; i < byte_lanes; i++) begin
          if (wr1.be[i]) begin
            own_q[wr1.addr][i] <= 1'b1;
          end
        end
      end
    end
  end

  // ========================================
  // Lookup, one per read port
  // ========================================

  always_comb begin
    for (int k = 0; k < NUM_READ; k++) begin
      owner[k] = own_q[ra[k]];
    end
  end

endmodule

//--- regfile_read_port.sv
`timescale 1ns/1ns

module regfile_read_port (
  input  logic [regfile_pkg::data_wid-1:0]   pc,
  input  regfile_pkg::reg_addr_t            ra,
  input  regfile_pkg::wr_port_t             wr0,
  input  regfile_pkg::wr_port_t             wr1,
  input  logic [regfile_pkg::data_wid-1:0]   bank0,
  input  logic [regfile_pkg::data_wid-1:0]   bank1,
  input  logic [regfile_pkg::byte_lanes-1:0] owner,
  output logic [regfile_pkg::data_wid-1:0]   rd
);

  import regfile_pkg::*;

  // Byte views of the two bank words and the two write payloads
  reg_word_u b0_u;
  reg_word_u b1_u;
  reg_word_u w0_u;
  reg_word_u w1_u;

  // Result of the lane merge before the special registers are applied
  reg_word_u merged;

  // Address matches for same-cycle forwarding
  logic hit0;
  logic hit1;

  assign b0_u.word = bank0;
  assign b1_u.word = bank1;
  assign w0_u.word = wr0.data;
  assign w1_u.word = wr1.data;

  assign hit0 = wr0.en && (wr0.addr == ra);
  assign hit1 = wr1.en && (wr1.addr == ra);

  // ========================================
  // Lane merge
  // ========================================

  // Every lane shows the value it will hold after the coming edge
  // Port 1 beats port 0, the same way the table settles a collision
  always_comb begin
    for (int i = 0; i < byte_lanes; i++) begin
      if (hit1 && wr1.be[i]) begin
        merged.lanes[i] = w1_u.lanes[i];
      end else if (hit0 && wr0.be[i]) begin
        merged.lanes[i] = w0_u.lanes[i];
      end else if (owner[i]) begin
        merged.lanes[i] = b1_u.lanes[i];
      end else begin
        merged.lanes[i] = b0_u.lanes[i];
      end
    end
  end

  // ========================================
  // Special registers
  // ========================================

  // Register 0 and the pc register ignore the storage completely,
  // so writes to them have no visible effect
  always_comb begin
    if (ra == zero_reg) begin
      rd = '0;
    end else if (ra == pc_reg) begin
      rd = pc;
    end else begin
      rd = merged.word;
    end
  end

endmodule

//--- regfile_2w4r.sv
`timescale 1ns/1ns

module regfile_2w4r #(
  parameter int NUM_READ = 4,
  parameter int DEPTH    = 64
) (
  input  logic                            clka,
  input  logic                            reset,
  input  regfile_pkg::wr_port_t           wr0,
  input  regfile_pkg::wr_port_t           wr1,
  input  logic [regfile_pkg::data_wid-1:0] pc0,
  input  logic [regfile_pkg::data_wid-1:0] pc1,
  input  regfile_pkg::reg_addr_t          ra [NUM_READ],
  output logic [regfile_pkg::data_wid-1:0] rd [NUM_READ]
);

  import regfile_pkg::*;

  // Per read port outputs of the two banks
  logic [data_wid-1:0] bank0_rd [NUM_READ];
  logic [data_wid-1:0] bank1_rd [NUM_READ];

  // Per read port owner vector from the live-value table
  logic [byte_lanes-1:0] owner [NUM_READ];

  // ========================================
  // Live-value table
  // ========================================

  regfile_lvt #(
    .NUM_READ (NUM_READ)
  ) u_lvt (
    .clka  (clka),
    .reset (reset),
    .wr0   (wr0),
    .wr1   (wr1),
    .ra    (ra),
    .owner (owner)
  );

  // ========================================
  // Banks and read ports
  // ========================================

  // Every read port gets a private copy of both banks, so each RAM
  // only needs one write port and one read port
  for (genvar k = 0; k < NUM_READ; k++) begin : g_port

    // Bank 0 follows write port 0
    regfile_bank_ram #(
      .DEPTH (DEPTH)
    ) u_bank0 (
      .clka  (clka),
      .wr    (wr0),
      .raddr (ra[k]),
      .rdata (bank0_rd[k])
    );

    // Bank 1 follows write port 1
    regfile_bank_ram #(
      .DEPTH (DEPTH)
    ) u_bank1 (
      .clka  (clka),
      .wr    (wr1),
      .raddr (ra[k]),
      .rdata (bank1_rd[k])
    );

    // The lower half of the read ports serves the first issue group
    // and sees pc0, the upper half sees pc1
    regfile_read_port u_rport (
      .pc    ((k < NUM_READ / 2) ? pc0 : pc1),
      .ra    (ra[k]),
      .wr0   (wr0),
      .wr1   (wr1),
      .bank0 (bank0_rd[k]),
      .bank1 (bank1_rd[k]),
      .owner (owner[k]),
      .rd    (rd[k])
    );

  end

endmodule

//--- tb_regfile_properties.sv
`timescale 1ns/1ns

module tb_regfile_properties #(
  parameter int NUM_READ = 4
) (
  input logic                               clka,
  input logic                               reset,
  input regfile_pkg::wr_port_t              wr0,
  input regfile_pkg::wr_port_t              wr1,
  input logic [regfile_pkg::data_wid-1:0]   pc0,
  input logic [regfile_pkg::data_wid-1:0]   pc1,
  input regfile_pkg::reg_addr_t             ra    [NUM_READ],
  input logic [regfile_pkg::data_wid-1:0]   rd    [NUM_READ],
  input logic [regfile_pkg::byte_lanes-1:0] owner [NUM_READ]
);

  import regfile_pkg::*;

  for (genvar k = 0; k < NUM_READ; k++) begin : g_port

    // pc of the issue group this read port belongs to
    logic [data_wid-1:0] grp_pc;
    logic                plain;

    assign grp_pc = (k < NUM_READ / 2) ? pc0 : pc1;
    assign plain  = (ra[k] != zero_reg) && (ra[k] != pc_reg);

    // ========================================
    // Special registers
    // ========================================

    a_zero_reg: assert property (@(posedge clka) (ra[k] == zero_reg) |-> (rd[k] == '0))
      else $error("time %0t rd[%0d] for register 0 expected 0 actual %h",
                  $time, k, $sampled(rd[k]));

    a_pc_reg: assert property (@(posedge clka) (ra[k] == pc_reg) |-> (rd[k] == grp_pc))
      else $error("time %0t rd[%0d] for register 53 expected %h actual %h",
                  $time, k, $sampled(grp_pc), $sampled(rd[k]));

    // Ownership must be back on bank 0 right after a reset edge
    a_owner_reset: assert property (@(posedge clka) reset |=> (owner[k] == '0))
      else $error("time %0t owner[%0d] after reset expected 00 actual %h",
                  $time, k, $sampled(owner[k]));

    // ========================================
    // Same-cycle forwarding, lane by lane
    // ========================================

    for (genvar i = 0; i < byte_lanes; i++) begin : g_lane
      logic hit0;
      logic hit1;

      assign hit0 = wr0.en && wr0.be[i] && (wr0.addr == ra[k]) && plain;
      assign hit1 = wr1.en && wr1.be[i] && (wr1.addr == ra[k]) && plain;

      a_fwd_wr1: assert property (@(posedge clka)
        hit1 |-> (rd[k][8*i +: 8] == wr1.data[8*i +: 8]))
        else $error("time %0t rd[%0d] lane %0d from write port 1 expected %h actual %h",
                    $time, k, i, $sampled(wr1.data[8*i +: 8]),
                    $sampled(rd[k][8*i +: 8]));

      // Port 1 takes the lane on a collision, so port 0 only counts alone
      a_fwd_wr0: assert property (@(posedge clka)
        (hit0 && !hit1) |-> (rd[k][8*i +: 8] == wr0.data[8*i +: 8]))
        else $error("time %0t rd[%0d] lane %0d from write port 0 expected %h actual %h",
                    $time, k, i, $sampled(wr0.data[8*i +: 8]),
                    $sampled(rd[k][8*i +: 8]));
    end

  end

endmodule

//--- tb_regfile.sv
`timescale 1ns/1ns

module tb_regfile;

  import regfile_pkg::*;

  localparam int num_read  = 4;
  localparam int clk_half  = 4;
  localparam int n_mixed   = 96;
  localparam int n_collide = 16;
  localparam int n_forward = 24;
  localparam int n_special = 16;
  localparam int n_random  = 300;

  // Length of the whole run in cycles with reset and settle cycles included
  localparam int test_cycles = 4 + (2 * reg_count + 2) + (n_mixed + 10) + (n_collide + 6)
                             + (n_forward + 2) + (n_special + 2)
                             + (2 * n_random + reg_count + 4);
  localparam int cycle_limit = 3 * test_cycles;

  logic                clka;
  logic                reset;
  wr_port_t            wr0;
  wr_port_t            wr1;
  logic [data_wid-1:0] pc0;
  logic [data_wid-1:0] pc1;
  reg_addr_t           ra [num_read];
  logic [data_wid-1:0] rd [num_read];

  // The reference model keeps the latest byte of every register and which bytes are defined
  logic [data_wid-1:0]   shadow [reg_count];
  logic [byte_lanes-1:0] known  [reg_count] = '{default: '0};

  logic [31:0] rng_state = 32'h44046e54;
  int          err_count = 0;
  int          pass_count;
  int          fail_count;
  int          cycle_count;

  regfile_2w4r #(
    .NUM_READ (num_read),
    .DEPTH    (reg_count)
  ) i_dut (
    .clka  (clka),
    .reset (reset),
    .wr0   (wr0),
    .wr1   (wr1),
    .pc0   (pc0),
    .pc1   (pc1),
    .ra    (ra),
    .rd    (rd)
  );

  bind regfile_2w4r tb_regfile_properties #(
    .NUM_READ (NUM_READ)
  ) i_props (
    .clka  (clka),
    .reset (reset),
    .wr0   (wr0),
    .wr1   (wr1),
    .pc0   (pc0),
    .pc1   (pc1),
    .ra    (ra),
    .rd    (rd),
    .owner (owner)
  );

  initial begin
    clka = 1'b0;
    forever begin
      #clk_half clka = ~clka;
    end
  end

  // ========================================
  // Random numbers and stimulus helpers
  // ========================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function logic [63:0] next_rand64();
    return {next_rand32(), next_rand32()};
  endfunction

  // Any register except the two special ones
  function reg_addr_t pick_plain_reg();
    reg_addr_t a;
    a = reg_addr_t'(next_rand32());
    while (a == zero_reg || a == pc_reg) begin
      a = reg_addr_t'(next_rand32());
    end
    return a;
  endfunction

  function automatic wr_port_t make_write(input reg_addr_t addr, input logic [7:0] lanes_en,
                                          input logic [63:0] data);
    wr_port_t w;
    w.en   = 1'b1;
    w.be   = lanes_en;
    w.addr = addr;
    w.data = data;
    return w;
  endfunction

  task automatic same_reads(input reg_addr_t a);
    for (int k = 0; k < num_read; k++) begin
      ra[k] <= a;
    end
  endtask

  // Ports start a quarter of the register space apart
  task automatic spread_reads(input int base);
    for (int k = 0; k < num_read; k++) begin
      ra[k] <= reg_addr_t'(base + k * (reg_count / num_read));
    end
  endtask

  task automatic random_reads();
    for (int k = 0; k < num_read; k++) begin
      ra[k] <= reg_addr_t'(next_rand32());
    end
  endtask

  task automatic idle_writes();
    wr0 <= '0;
    wr1 <= '0;
  endtask

  // One idle cycle reads the stored state and one more lets the check land
  task automatic settle();
    @(posedge clka);
    idle_writes();
    @(posedge clka);
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    if (err_count == errs_at_start) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: %0d mismatches", name, err_count - errs_at_start);
    end
  endtask

  // ========================================
  // Reference model and read checker
  // ========================================

  // Port 1 updates come after port 0, so a collision leaves port 1's byte
  always @(posedge clka) begin
    for (int i = 0; i < byte_lanes; i++) begin
      if (wr0.en && wr0.be[i]) begin
        shadow[wr0.addr][8*i +: 8] <= wr0.data[8*i +: 8];
        known[wr0.addr][i]         <= 1'b1;
      end
    end
    for (int i = 0; i < byte_lanes; i++) begin
      if (wr1.en && wr1.be[i]) begin
        shadow[wr1.addr][8*i +: 8] <= wr1.data[8*i +: 8];
        known[wr1.addr][i]         <= 1'b1;
      end
    end
  end

  // Value a read should show, and which of its bytes are defined at all
  task automatic predict_read(input reg_addr_t a, input logic [63:0] pc,
                              output logic [63:0] val, output logic [63:0] mask);
    val  = '0;
    mask = '1;
    if (a == zero_reg) begin
      val = '0;
    end else if (a == pc_reg) begin
      val = pc;
    end else begin
      for (int i = 0; i < byte_lanes; i++) begin
        if (wr1.en && wr1.addr == a && wr1.be[i]) begin
          val[8*i +: 8] = wr1.data[8*i +: 8];
        end else if (wr0.en && wr0.addr == a && wr0.be[i]) begin
          val[8*i +: 8] = wr0.data[8*i +: 8];
        end else begin
          val[8*i +: 8]  = shadow[a][8*i +: 8];
          mask[8*i +: 8] = {8{known[a][i]}};
        end
      end
    end
  endtask

  // Inputs change on the rising edge, so the falling edge sees them settled
  always @(negedge clka) begin : read_check
    logic [63:0] exp_val;
    logic [63:0] exp_mask;
    for (int k = 0; k < num_read; k++) begin
      predict_read(ra[k], (k < num_read / 2) ? pc0 : pc1, exp_val, exp_mask);
      assert (((rd[k] ^ exp_val) & exp_mask) === 64'd0) else begin
        $display("Error: time %0t rd[%0d] expected %h actual %h",
                 $time, k, exp_val, rd[k]);
        err_count++;
      end
    end
  end

  // ========================================
  // Tests
  // ========================================

  task automatic full_word_readback();
    int errs;
    errs = err_count;
    for (int r = 0; r < reg_count; r++) begin
      @(posedge clka);
      wr0 <= make_write(reg_addr_t'(r), 8'hff, next_rand64());
      wr1 <= '0;
      same_reads(reg_addr_t'(r));
    end
    for (int r = 0; r < reg_count; r++) begin
      @(posedge clka);
      idle_writes();
      spread_reads(r);
    end
    settle();
    finish_test("full word", errs);
  endtask

  task automatic ownership_mix();
    int        errs;
    reg_addr_t a;
    wr_port_t  w;
    errs = err_count;
    // Each register of 10..17 gets a port 0 write and then a port 1 write
    for (int n = 0; n < n_mixed; n++) begin
      @(posedge clka);
      a = reg_addr_t'(10 + (n / 2) % 8);
      w = make_write(a, 8'(next_rand32()), next_rand64());
      if (n % 2 == 0) begin
        wr0 <= w;
        wr1 <= '0;
      end else begin
        wr0 <= '0;
        wr1 <= w;
      end
      for (int k = 0; k < num_read; k++) begin
        ra[k] <= reg_addr_t'(10 + (n + 2 * k) % 8);
      end
    end
    for (int c = 0; c < 2; c++) begin
      @(posedge clka);
      idle_writes();
      for (int k = 0; k < num_read; k++) begin
        ra[k] <= reg_addr_t'(10 + 4 * c + k);
      end
    end
    settle();
    finish_test("mixed ownership", errs);
  endtask

  task automatic write_collision();
    int          errs;
    reg_addr_t   a;
    reg_addr_t   prev;
    logic [7:0]  be0;
    logic [7:0]  be1;
    errs = err_count;
    prev = pick_plain_reg();
    for (int n = 0; n < n_collide; n++) begin
      @(posedge clka);
      a   = pick_plain_reg();
      // Lane 4 is always enabled on both ports
      be0 = 8'(next_rand32()) | 8'h18;
      be1 = 8'(next_rand32()) | 8'h10;
      wr0 <= make_write(a, be0, next_rand64());
      wr1 <= make_write(a, be1, next_rand64());
      ra[0] <= a;
      ra[1] <= prev;
      ra[2] <= a;
      ra[3] <= prev;
      prev = a;
    end
    settle();
    finish_test("collision", errs);
  endtask

  task automatic same_cycle_forward();
    int        errs;
    reg_addr_t a;
    errs = err_count;
    // Cycles rotate between port 0 alone, port 1 alone and both ports
    for (int n = 0; n < n_forward; n++) begin
      @(posedge clka);
      a = pick_plain_reg();
      if (n % 3 == 1) begin
        wr0 <= '0;
      end else begin
        wr0 <= make_write(a, 8'(next_rand32()), next_rand64());
      end
      if (n % 3 == 0) begin
        wr1 <= '0;
      end else begin
        wr1 <= make_write(a, 8'(next_rand32()), next_rand64());
      end
      same_reads(a);
    end
    settle();
    finish_test("forwarding", errs);
  endtask

  task automatic special_regs();
    int          errs;
    logic [63:0] p;
    errs = err_count;
    for (int n = 0; n < n_special; n++) begin
      @(posedge clka);
      p = next_rand64();
      pc0 <= p;
      pc1 <= ~p;
      wr0 <= make_write((n % 2 == 0) ? zero_reg : pc_reg, 8'hff, next_rand64());
      wr1 <= make_write((n % 2 == 0) ? pc_reg : zero_reg, 8'hff, next_rand64());
      for (int k = 0; k < num_read; k++) begin
        ra[k] <= ((n + k) % 2 == 0) ? zero_reg : pc_reg;
      end
    end
    settle();
    finish_test("special registers", errs);
  endtask

  task automatic random_cycle();
    logic [31:0] r;
    reg_addr_t   a0;
    reg_addr_t   a1;
    r  = next_rand32();
    a0 = reg_addr_t'(next_rand32());
    // Now and then both ports aim at the same register
    a1 = r[2] ? a0 : reg_addr_t'(next_rand32());
    @(posedge clka);
    if (r[0]) begin
      wr0 <= make_write(a0, 8'(next_rand32()), next_rand64());
    end else begin
      wr0 <= '0;
    end
    if (r[1]) begin
      wr1 <= make_write(a1, 8'(next_rand32()), next_rand64());
    end else begin
      wr1 <= '0;
    end
    random_reads();
  endtask

  task automatic traffic_with_reset();
    int          errs;
    logic [63:0] d;
    errs = err_count;
    for (int n = 0; n < n_random; n++) begin
      random_cycle();
    end
    // Bank 0 must hold every latest value before the table is cleared
    // Port 1 writes the same word, so bank 1 owns every lane when reset comes
    for (int r = 0; r < reg_count; r++) begin
      @(posedge clka);
      d = next_rand64();
      wr0 <= make_write(reg_addr_t'(r), 8'hff, d);
      wr1 <= make_write(reg_addr_t'(r), 8'hff, d);
      random_reads();
    end
    @(posedge clka);
    idle_writes();
    reset <= 1'b1;
    random_reads();
    @(posedge clka);
    reset <= 1'b0;
    random_reads();
    for (int n = 0; n < n_random; n++) begin
      random_cycle();
    end
    settle();
    finish_test("random traffic", errs);
  endtask

  // ========================================
  // Main sequence and timeout
  // ========================================

  initial begin
    pass_count = 0;
    fail_count = 0;
    reset      = 1'b1;
    wr0        = '0;
    wr1        = '0;
    pc0        = 64'h0000_0000_8000_1000;
    pc1        = 64'h0000_0000_8000_2040;
    for (int k = 0; k < num_read; k++) begin
      ra[k] = zero_reg;
    end
    repeat (4) @(posedge clka);
    reset <= 1'b0;

    full_word_readback();
    ownership_mix();
    write_collision();
    same_cycle_forward();
    special_regs();
    traffic_with_reset();

    $display("summary: %0d passed, %0d failed, %0d mismatches",
             pass_count, fail_count, err_count);
    if (fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clka);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("tests failed");
    $finish;
  end

endmodule

//--- tb.f
regfile_pkg.sv
regfile_bank_ram.sv
regfile_lvt.sv
regfile_read_port.sv
regfile_2w4r.sv
tb_regfile_properties.sv
tb_regfile.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the register file testbench with Verilator.
# Exit status is nonzero when the build fails, the simulation
# fails, or the log contains the testbench's failure line.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
OBJ_DIR=obj_dir
SIM_BIN=tb_regfile_sim

if ! command -v verilator >/dev/null 2>&1; then
  echo "run_sim: verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --top-module tb_regfile \
  -Mdir "$OBJ_DIR" -o "$SIM_BIN" \
  -f tb.f > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "run_sim: build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "run_sim: simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$SIM_LOG"; then
  echo "run_sim: FAIL"
  exit 1
fi

echo "run_sim: PASS"
exit 0
